// File: test/rv_cases.txt
# P word-addr instr | D word-addr data | R word-addr (random initial data)
# S name store-word-addr data | C name store-word-addr source-word-addr (copy of initial data)
P 00 05a00093  addi x1, x0, 90
P 01 ffd00113  addi x2, x0, -3
P 02 002081b3  add  x3, x1, x2
P 03 08302023  sw   x3, 128(x0)
P 04 40208233  sub  x4, x1, x2
P 05 00400513  addi x10, x0, 4
P 06 08402223  sw   x4, 132(x0)
P 07 001272b3  and  x5, x4, x1
P 08 00a2e333  or   x6, x5, x10
P 09 002343b3  xor  x7, x6, x2
P 0a 08702423  sw   x7, 136(x0)
P 0b 00112433  slt  x8, x2, x1
P 0c 00a094b3  sll  x9, x1, x10
P 0d 00a155b3  srl  x11, x2, x10
P 0e 40a15633  sra  x12, x2, x10
P 0f 009406b3  add  x13, x8, x9
P 10 08d02623  sw   x13, 140(x0)
P 11 08b02823  sw   x11, 144(x0)
P 12 08c02a23  sw   x12, 148(x0)
P 13 0f017713  andi x14, x2, 0xf0
P 14 f0076793  ori  x15, x14, -256
P 15 fff7c813  xori x16, x15, -1
P 16 ffe12893  slti x17, x2, -2
P 17 00881913  slli x18, x16, 8
P 18 01c15993  srli x19, x2, 28
P 19 40115a13  srai x20, x2, 1
P 1a 01190ab3  add  x21, x18, x17
P 1b 09502c23  sw   x21, 152(x0)
P 1c 413a0b33  sub  x22, x20, x19
P 1d 09602e23  sw   x22, 156(x0)
P 1e 04002b83  lw   x23, 64(x0)
P 1f 064b8c13  addi x24, x23, 100
P 20 0b802023  sw   x24, 160(x0)
P 21 04402c83  lw   x25, 68(x0)
P 22 0b902223  sw   x25, 164(x0)
P 23 04802d03  lw   x26, 72(x0)
P 24 0ba02423  sw   x26, 168(x0)
P 25 03700013  addi x0, x0, 55
P 26 0a002623  sw   x0, 172(x0)
D 10 00000007
D 11 12345678
R 12
S add_fwd_d1_d2    20 00000057
S sub_bypass_d3    21 0000005d
S and_or_xor       22 ffffffa1
S slt_sll          23 000005a1
S srl              24 0fffffff
S sra              25 ffffffff
S imm_logic_shift  26 00000f01
S imm_shifts_sub   27 ffffffef
S load_use         28 0000006b
S load_then_store  29 12345678
C rand_copy        2a 12
S x0_write         2b 00000000

// File: project.f
+incdir+verilog
verilog/rvPkg.sv
verilog/fetchStage.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/rvPipeline.sv
test/tbRvPipeline.sv

// File: Bender.yml
package:
  name: rv_pipeline

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rvPkg.sv
      - verilog/fetchStage.sv
      - verilog/regFile.sv
      - verilog/decodeStage.sv
      - verilog/executeStage.sv
      - verilog/memWbStage.sv
      - verilog/rvPipeline.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tbRvPipeline.sv

// File: test/tbRvPipeline.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module tbRvPipeline;

    localparam int MEM_WORDS     = 256;
    localparam int STORE_TIMEOUT = 200;

    logic                   clk;
    logic                   rst_n;
    logic [`MEM_ADDR_W-1:0] imemAddr;
    logic [`XLEN-1:0]       imemData;
    logic                   dmemRead;
    logic                   dmemWrite;
    logic [`MEM_ADDR_W-1:0] dmemAddr;
    logic [`XLEN-1:0]       dmemWdata;
    logic [`XLEN-1:0]       dmemRdata;

    logic [`XLEN-1:0] imem [MEM_WORDS];
    logic [`XLEN-1:0] dmem [MEM_WORDS];

    // expected stores in program order
    string                  expName [$];
    logic [`MEM_ADDR_W-1:0] expAddr [$];
    logic [`XLEN-1:0]       expData [$];

    int passCount;
    int failCount;

    rvPipeline DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .dmemRead  (dmemRead),
        .dmemWrite (dmemWrite),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata),
        .dmemRdata (dmemRdata)
    );

    always #20 clk = ~clk;

    // both memories answer in the same cycle
    assign imemData  = (imemAddr < MEM_WORDS) ? imem[imemAddr[7:0]] : '0;
    assign dmemRdata = (dmemRead && (dmemAddr < MEM_WORDS)) ? dmem[dmemAddr[7:0]] : '0;

    task automatic fillMemories();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {i[11:0], 20'h00013}; // addi x0, x0, i
            dmem[i] = 32'hd0000000 | i;
        end
    endtask

    task automatic loadCases();
        int          fd;
        int          n;
        string       line;
        string       kind;
        string       name;
        logic [31:0] addr;
        logic [31:0] value;
        fd = $fopen("test/rv_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/rv_cases.txt");
            failCount++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            kind = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%s", kind);
            if (kind == "P") begin
                n = $sscanf(line, "%s %h %h", kind, addr, value);
                imem[addr[7:0]] = value;
            end else if (kind == "D") begin
                n = $sscanf(line, "%s %h %h", kind, addr, value);
                dmem[addr[7:0]] = value;
            end else if (kind == "R") begin
                n = $sscanf(line, "%s %h", kind, addr);
                dmem[addr[7:0]] = $urandom;
            end else if ((kind == "S") || (kind == "C")) begin
                n = $sscanf(line, "%s %s %h %h", kind, name, addr, value);
                if (kind == "C") begin
                    value = dmem[value[7:0]]; // copy of an initial data word
                end
                expName.push_back(name);
                expAddr.push_back(addr[`MEM_ADDR_W-1:0]);
                expData.push_back(value);
            end
        end
        $fclose(fd);
        if (expName.size() == 0) begin
            $display("No expected stores found in the cases file");
            failCount++;
        end
    endtask

    task automatic checkAddr(
        input  string                  name,
        input  logic [`MEM_ADDR_W-1:0] expected,
        input  logic [`MEM_ADDR_W-1:0] actual,
        output bit                     ok
    );
        ok = (actual === expected);
        if (!ok) begin
            $display("Fail %0s address: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkData(
        input  string            name,
        input  logic [`XLEN-1:0] expected,
        input  logic [`XLEN-1:0] actual,
        output bit               ok
    );
        ok = (actual === expected);
        if (!ok) begin
            $display("Fail %0s data: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic recordResult(input string name, input bit ok);
        if (ok) begin
            passCount++;
            $display("Pass %0s", name);
        end else begin
            failCount++;
        end
    endtask

    // outputs are settled at the falling edge
    task automatic waitForStore(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && (cycles < STORE_TIMEOUT)) begin
            @(negedge clk);
            cycles++;
            seen = (dmemWrite === 1'b1);
        end
    endtask

    initial begin
        int seedInit;
        bit seen;
        bit timedOut;
        bit okAddr;
        bit okData;
        clk       = 1'b0;
        rst_n     = 1'b0;
        passCount = 0;
        failCount = 0;
        timedOut  = 1'b0;
        seedInit  = $urandom(32'h745c);
        fillMemories();
        loadCases();

        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;

        // idle data port, fetch from address zero
        @(negedge clk);
        checkAddr("reset_state", '0, imemAddr, okAddr);
        checkData("reset_state", '0, {{(`XLEN-2){1'b0}}, dmemRead, dmemWrite}, okData);
        recordResult("reset_state", okAddr && okData);

        for (int i = 0; (i < expName.size()) && !timedOut; i++) begin
            waitForStore(seen);
            if (!seen) begin
                $display("Store %0s never arrived within %0d cycles", expName[i], STORE_TIMEOUT);
                failCount++;
                timedOut = 1'b1;
            end else begin
                checkAddr(expName[i], expAddr[i], dmemAddr, okAddr);
                checkData(expName[i], expData[i], dmemWdata, okData);
                recordResult(expName[i], okAddr && okData);
                if (dmemAddr < MEM_WORDS) begin
                    dmem[dmemAddr[7:0]] = dmemWdata; // memory takes the store
                end
            end
        end

        $display("Tests done: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog/rvPipeline.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rvPipeline (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic [`MEM_ADDR_W-1:0] imemAddr,
    input  logic [`XLEN-1:0]       imemData,
    output logic                   dmemRead,
    output logic                   dmemWrite,
    output logic [`MEM_ADDR_W-1:0] dmemAddr,
    output logic [`XLEN-1:0]       dmemWdata,
    input  logic [`XLEN-1:0]       dmemRdata
);

    import rvPkg::*;

    ifIdReg_s  ifId;
    idExReg_s  idEx;
    exMemReg_s exMem;
    wbPort_s   wb;
    logic      loadUseStall;

    fetchStage fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .loadUseStall (loadUseStall),
        .imemData     (imemData),
        .imemAddr     (imemAddr),
        .ifId         (ifId)
    );

    decodeStage decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .ifId         (ifId),
        .wb           (wb),
        .loadUseStall (loadUseStall),
        .idEx         (idEx)
    );

    executeStage execute (
        .clk   (clk),
        .rst_n (rst_n),
        .idEx  (idEx),
        .wb    (wb),
        .exMem (exMem)
    );

    memWbStage memWbStg (
        .clk       (clk),
        .rst_n     (rst_n),
        .exMem     (exMem),
        .dmemRdata (dmemRdata),
        .wb        (wb)
    );

    // data port straight from EX/MEM
    assign dmemRead  = exMem.ctrl.memRead;
    assign dmemWrite = exMem.ctrl.memWrite;
    assign dmemAddr  = exMem.aluResult[`XLEN-1:2];
    assign dmemWdata = exMem.storeData;

endmodule

// File: verilog/memWbStage.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module memWbStage (
    input  logic             clk,
    input  logic             rst_n,
    input  rvPkg::exMemReg_s exMem,
    input  logic [`XLEN-1:0] dmemRdata,
    output rvPkg::wbPort_s   wb
);

    import rvPkg::*;

    memWbReg_s memWb;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            memWb <= '0;
        end else begin
            memWb.regWrite  <= exMem.ctrl.regWrite;
            memWb.memToReg  <= exMem.ctrl.memToReg;
            memWb.loadData  <= dmemRdata; // read data valid same cycle
            memWb.aluResult <= exMem.aluResult;
            memWb.rd        <= exMem.rd;
        end
    end

    assign wb.we   = memWb.regWrite;
    assign wb.rd   = memWb.rd;
    assign wb.data = memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module executeStage (
    input  logic             clk,
    input  logic             rst_n,
    input  rvPkg::idExReg_s  idEx,
    input  rvPkg::wbPort_s   wb,
    output rvPkg::exMemReg_s exMem
);

    import rvPkg::*;

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] rs2Fwd;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluOut;
    aluSel_e          aluSel;

    // EX/MEM wins over writeback, register value last
    function automatic logic [`XLEN-1:0] forwardOperand(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`XLEN-1:0]       regVal,
        input exMemReg_s              exm,
        input wbPort_s                w
    );
        if (exm.ctrl.regWrite && (exm.rd != '0) && (exm.rd == rs)) begin
            return exm.aluResult;
        end else if (w.we && (w.rd != '0) && (w.rd == rs)) begin
            return w.data;
        end
        return regVal;
    endfunction

    assign opA    = forwardOperand(idEx.rs1, idEx.rs1Data, exMem, wb);
    assign rs2Fwd = forwardOperand(idEx.rs2, idEx.rs2Data, exMem, wb);
    assign opB    = idEx.ctrl.aluSrc ? idEx.imm : rs2Fwd;

    always_comb begin
        aluSel = ADD; // loads and stores add the offset
        if (idEx.ctrl.isImmOp || !idEx.ctrl.aluSrc) begin
            case (idEx.funct3)
                3'b000: aluSel = (!idEx.ctrl.isImmOp && idEx.funct7b5) ? SUB : ADD;
                3'b001: aluSel = SLL;
                3'b010: aluSel = SLT;
                3'b100: aluSel = XOR;
                3'b101: aluSel = idEx.funct7b5 ? SRA : SRL;
                3'b110: aluSel = OR;
                3'b111: aluSel = AND;
                default: aluSel = ADD; // sltu not implemented
            endcase
        end
    end

    always_comb begin
        case (aluSel)
            AND:     aluOut = opA & opB;
            OR:      aluOut = opA | opB;
            ADD:     aluOut = opA + opB;
            SLL:     aluOut = opA << opB[4:0];
            SRL:     aluOut = opA >> opB[4:0];
            SRA:     aluOut = $signed(opA) >>> opB[4:0];
            SUB:     aluOut = opA - opB;
            SLT:     aluOut = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            XOR:     aluOut = opA ^ opB;
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exMem <= '0;
        end else begin
            exMem.ctrl      <= idEx.ctrl;
            exMem.aluResult <= aluOut;
            exMem.storeData <= rs2Fwd; // forwarded, not the stale ID/EX copy
            exMem.rd        <= idEx.rd;
        end
    end

endmodule

// File: verilog/decodeStage.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module decodeStage (
    input  logic            clk,
    input  logic            rst_n,
    input  rvPkg::ifIdReg_s ifId,
    input  rvPkg::wbPort_s  wb,
    output logic            loadUseStall,
    output rvPkg::idExReg_s idEx
);

    import rvPkg::*;

    instrWord_u       instr;
    ctrl_s            ctrl;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rfRs1Data;
    logic [`XLEN-1:0] rfRs2Data;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;

    assign instr = ifId.instr;

    always_comb begin
        ctrl = '0;
        if (ifId.valid) begin
            case (instr.r.opcode)
                OP: ctrl.regWrite = 1'b1;
                OP_IMM: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.isImmOp  = 1'b1;
                end
                LOAD: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
                STORE: begin
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
                default: ctrl = '0; // unsupported opcode acts as a nop
            endcase
        end
    end

    // S splits the low immediate bits into the rd field
    assign imm = (instr.i.opcode == STORE)
               ? {{20{instr.i.immHi[6]}}, instr.i.immHi, instr.i.rdOrImmLo}
               : {{20{instr.i.immHi[6]}}, instr.i.immHi, instr.i.rs2orImm};

    regFile regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (instr.r.rs1),
        .rs2     (instr.r.rs2),
        .wb      (wb),
        .rs1Data (rfRs1Data),
        .rs2Data (rfRs2Data)
    );

    // write-through of the register being written this cycle
    assign rs1Data = (wb.we && (wb.rd != '0) && (wb.rd == instr.r.rs1)) ? wb.data : rfRs1Data;
    assign rs2Data = (wb.we && (wb.rd != '0) && (wb.rd == instr.r.rs2)) ? wb.data : rfRs2Data;

    // load in EX whose result the instruction here needs
    assign loadUseStall = idEx.ctrl.memRead && (idEx.rd != '0)
                       && ((idEx.rd == instr.r.rs1) || (idEx.rd == instr.r.rs2));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idEx <= '0;
        end else begin
            idEx.ctrl     <= loadUseStall ? '0 : ctrl; // bubble
            idEx.funct3   <= instr.r.funct3;
            idEx.funct7b5 <= instr.r.funct7[5];
            idEx.rs1Data  <= rs1Data;
            idEx.rs2Data  <= rs2Data;
            idEx.imm      <= imm;
            idEx.rs1      <= instr.r.rs1;
            idEx.rs2      <= instr.r.rs2;
            idEx.rd       <= instr.r.rd;
        end
    end

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  rvPkg::wbPort_s         wb,
    output logic [`XLEN-1:0]       rs1Data,
    output logic [`XLEN-1:0]       rs2Data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // plain array reads, bypass lives in decode
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data; // x0 stays zero
        end
    end

endmodule

// File: verilog/fetchStage.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module fetchStage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   loadUseStall,
    input  logic [`XLEN-1:0]       imemData,
    output logic [`MEM_ADDR_W-1:0] imemAddr,
    output rvPkg::ifIdReg_s        ifId
);

    logic [`XLEN-1:0] pc;

    assign imemAddr = pc[`XLEN-1:2]; // word address

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc   <= '0;
            ifId <= '0;
        end else if (!loadUseStall) begin
            pc         <= pc + `XLEN'd4;
            ifId.valid <= 1'b1;
            ifId.instr <= imemData;
        end
        // stalled: PC and IF/ID both hold
    end

endmodule

// File: verilog/rvPkg.sv
package rvPkg;

`include "rv_defines.svh"

    // major opcodes still decoded by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [`ALU_SEL_W-1:0] {
        AND = 4'd0,
        OR  = 4'd1,
        ADD = 4'd2,
        SLL = 4'd3,
        SRL = 4'd4,
        SRA = 4'd5,
        SUB = 4'd6,
        SLT = 4'd7,
        XOR = 4'd8
    } aluSel_e;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } rFormat_s;

    // I and S share the upper immediate bits
    typedef struct packed {
        logic [6:0]             immHi;
        logic [`REG_ADDR_W-1:0] rs2orImm;  // rs2 for S, imm[4:0] for I
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rdOrImmLo; // imm[4:0] for S
        logic [6:0]             opcode;
    } iFormat_s;

    typedef union packed {
        rFormat_s r;
        iFormat_s i;
    } instrWord_u;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic aluSrc;   // operand b from immediate
        logic isImmOp;  // OP_IMM, keeps funct7 from selecting sub
    } ctrl_s;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  instr;
    } ifIdReg_s;

    typedef struct packed {
        ctrl_s                  ctrl;
        logic [2:0]             funct3;
        logic                   funct7b5;
        logic [`XLEN-1:0]       rs1Data;
        logic [`XLEN-1:0]       rs2Data;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
    } idExReg_s;

    typedef struct packed {
        ctrl_s                  ctrl;
        logic [`XLEN-1:0]       aluResult;
        logic [`XLEN-1:0]       storeData;
        logic [`REG_ADDR_W-1:0] rd;
    } exMemReg_s;

    typedef struct packed {
        logic                   regWrite;
        logic                   memToReg;
        logic [`XLEN-1:0]       loadData;
        logic [`XLEN-1:0]       aluResult;
        logic [`REG_ADDR_W-1:0] rd;
    } memWbReg_s;

    // writeback bus, also the forwarding source two stages back
    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wbPort_s;

endpackage

// File: verilog/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath width
`define XLEN 32

// register file geometry
`define REG_ADDR_W 5
`define NUM_REGS 32

// word address on both memory ports, byte offset dropped
`define MEM_ADDR_W 30

// width of the ALU operation select
`define ALU_SEL_W 4

`endif
